/* huffman_encoder_macros.svh */
`ifndef HUFFMAN_ENCODER_MACROS_SVH
`define HUFFMAN_ENCODER_MACROS_SVH

// ############################################################
// datapath widths.
// ############################################################
`define HUFF_SYMBOL_BITS   8
`define HUFF_WORD_BITS     16
`define HUFF_MAX_CODE_BITS 17
// two maximum length codes fit side by side in the window.
`define HUFF_WINDOW_BITS   34

// ############################################################
// code classes of the static table.
// ############################################################
`define HUFF_SHORT_LEN     5
`define HUFF_MID_LEN       8
`define HUFF_LONG_LEN      17
`define HUFF_SHORT_LIMIT   16
`define HUFF_MID_LIMIT     80

`endif

/* huff_code_pkg.sv */
`include "huffman_encoder_macros.svh"

package huff_code_pkg;

   typedef logic [`HUFF_SYMBOL_BITS-1:0] symbol_t;
   // codes are right-aligned, the upper bits beyond len are zero.
   typedef logic [`HUFF_MAX_CODE_BITS-1:0] code_t;
   typedef logic [4:0] code_len_t;

   typedef struct packed {
      code_t     code;
      code_len_t len;
   } code_entry_t;

   // static table. the leading bits 0, 10 and 11 select the class,
   // which keeps the table prefix-free.
   function automatic code_entry_t code_of(symbol_t sym);
      code_entry_t result;
      symbol_t     offset;
      offset = sym - symbol_t'(`HUFF_SHORT_LIMIT);
      if (sym < symbol_t'(`HUFF_SHORT_LIMIT)) begin
         result.code = code_t'({1'b0, sym[3:0]});
         result.len  = code_len_t'(`HUFF_SHORT_LEN);
      end else if (sym < symbol_t'(`HUFF_MID_LIMIT)) begin
         result.code = code_t'({2'b10, offset[5:0]});
         result.len  = code_len_t'(`HUFF_MID_LEN);
      end else begin
         result.code = code_t'({2'b11, 7'b0000000, sym});
         result.len  = code_len_t'(`HUFF_LONG_LEN);
      end
      return result;
   endfunction

endpackage

/* huff_stream_pkg.sv */
`include "huffman_encoder_macros.svh"

package huff_stream_pkg;

   // number of bits waiting for a word to complete.
   typedef logic [5:0] fill_t;
   typedef logic [`HUFF_WINDOW_BITS-1:0] window_t;
   typedef logic [`HUFF_WORD_BITS-1:0] word_t;
   // number of completed words, 0, 1 or 2.
   typedef logic [1:0] emit_count_t;

   // ############################################################
   // pipeline stage payloads.
   // ############################################################

   // code with its bit offset in the stream and the words it completes.
   typedef struct packed {
      huff_code_pkg::code_entry_t entry;
      fill_t                      fill;
      emit_count_t                emit;
   } placed_code_t;

   // code placed in the window, keep is the remainder after emission.
   typedef struct packed {
      window_t     window;
      emit_count_t emit;
      fill_t       keep;
   } shifted_code_t;

   // output words, second is only meaningful when count is 2.
   typedef struct packed {
      emit_count_t count;
      word_t       first;
      word_t       second;
   } word_out_t;

endpackage

/* huff_code_rom.sv */
`timescale 1ns/10ps

// first stage of the encoder. the table is a rule, so the lookup
// reduces to a few comparators and muxes in front of the register.
module huff_code_rom (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       sym_valid,
   input  huff_code_pkg::symbol_t     sym,
   output huff_code_pkg::code_entry_t entry,
   output logic                       entry_valid
);

   huff_code_pkg::code_entry_t lookup;

   always_comb begin
      lookup = huff_code_pkg::code_of(sym);
   end

   // ############################################################
   // strobe register.
   // ############################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         entry_valid <= 1'b0;
      end else if (enable) begin
         entry_valid <= sym_valid;
      end
   end

   // ############################################################
   // code register.
   // ############################################################
   // the entry is only loaded for accepted symbols and otherwise
   // keeps the last code.
   always_ff @(posedge clk) begin
      if (enable && sym_valid) begin
         entry <= lookup;
      end
   end

endmodule

/* huff_fill_tracker.sv */
`timescale 1ns/10ps

// keeps the running count of bits that have not yet formed a word.
// the count always stays below one word, so a single code of up to
// 17 bits can complete at most two words.
module huff_fill_tracker (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enable,
   input  huff_code_pkg::code_entry_t    entry,
   input  logic                          entry_valid,
   output huff_stream_pkg::placed_code_t placed,
   output logic                          placed_valid
);

   huff_stream_pkg::fill_t       fill;
   huff_stream_pkg::fill_t       total;
   huff_stream_pkg::emit_count_t emit;

   // total is at most 15 + 17 = 32, so it fits in six bits.
   always_comb begin
      total = fill + huff_stream_pkg::fill_t'(entry.len);
      emit  = huff_stream_pkg::emit_count_t'(total >> 4);
   end

   // ############################################################
   // control state.
   // ############################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         fill         <= '0;
         placed_valid <= 1'b0;
      end else if (enable) begin
         placed_valid <= entry_valid;
         if (entry_valid) begin
            fill <= {2'b00, total[3:0]};
         end
      end
   end

   // the offset passed on is the fill before this code was added.
   always_ff @(posedge clk) begin
      if (enable && entry_valid) begin
         placed.entry <= entry;
         placed.fill  <= fill;
         placed.emit  <= emit;
      end
   end

endmodule

/* huff_code_shifter.sv */
`timescale 1ns/10ps
`include "huffman_encoder_macros.svh"

// left-aligns each code and shifts it down by its offset, so that
// its first bit lands right after the pending remainder bits.
module huff_code_shifter (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           enable,
   input  huff_stream_pkg::placed_code_t  placed,
   input  logic                           placed_valid,
   output huff_stream_pkg::shifted_code_t shifted,
   output logic                           shifted_valid
);

   logic [`HUFF_MAX_CODE_BITS-1:0] left_code;
   huff_stream_pkg::window_t       window;
   huff_stream_pkg::fill_t         total;
   huff_stream_pkg::fill_t         keep;

   always_comb begin
      left_code = placed.entry.code << (5'(`HUFF_MAX_CODE_BITS) - placed.entry.len);
      window    = {left_code, {(`HUFF_WINDOW_BITS-`HUFF_MAX_CODE_BITS){1'b0}}} >> placed.fill;
      // remainder once the completed words have left.
      total     = placed.fill + huff_stream_pkg::fill_t'(placed.entry.len);
      keep      = total - {placed.emit, 4'b0000};
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         shifted_valid <= 1'b0;
      end else if (enable) begin
         shifted_valid <= placed_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (enable && placed_valid) begin
         shifted.window <= window;
         shifted.emit   <= placed.emit;
         shifted.keep   <= keep;
      end
   end

endmodule

/* huff_word_assembler.sv */
`timescale 1ns/10ps
`include "huffman_encoder_macros.svh"

// last stage. merges the pending remainder with the shifted code and
// releases every word that is complete.
module huff_word_assembler (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           enable,
   input  huff_stream_pkg::shifted_code_t shifted,
   input  logic                           shifted_valid,
   output huff_stream_pkg::word_out_t     words
);

   localparam int LOW_BITS = `HUFF_WINDOW_BITS - `HUFF_WORD_BITS;

   // MSB-aligned bits that have not yet formed a word.
   huff_stream_pkg::word_t   remainder;
   huff_stream_pkg::window_t merged;
   huff_stream_pkg::word_t   next_rem;
   huff_stream_pkg::word_t   keep_mask;

   always_comb begin
      merged    = shifted.window | {remainder, {LOW_BITS{1'b0}}};
      keep_mask = ~({`HUFF_WORD_BITS{1'b1}} >> shifted.keep);
      case (shifted.emit)
         2'd0:    next_rem = merged[`HUFF_WINDOW_BITS-1 -: `HUFF_WORD_BITS];
         2'd1:    next_rem = merged[LOW_BITS-1 -: `HUFF_WORD_BITS];
         default: next_rem = {merged[LOW_BITS-`HUFF_WORD_BITS-1:0],
                              {(2*`HUFF_WORD_BITS-LOW_BITS){1'b0}}};
      endcase
   end

   // ############################################################
   // control state.
   // ############################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         words.count <= '0;
         remainder   <= '0;
      end else if (enable) begin
         if (shifted_valid) begin
            words.count <= shifted.emit;
            remainder   <= next_rem & keep_mask;
         end else begin
            words.count <= '0;
         end
      end
   end

   // ############################################################
   // output words.
   // ############################################################
   // the words hold their value until a new one completes.
   always_ff @(posedge clk) begin
      if (enable && shifted_valid) begin
         if (shifted.emit != 2'd0) begin
            words.first <= merged[`HUFF_WINDOW_BITS-1 -: `HUFF_WORD_BITS];
         end
         if (shifted.emit == 2'd2) begin
            words.second <= merged[LOW_BITS-1 -: `HUFF_WORD_BITS];
         end
      end
   end

endmodule

/* huffman_encoder.sv */
`timescale 1ns/10ps

// static-table huffman encoder. four stages of one enabled cycle each
// turn 8-bit symbols into a packed MSB-first stream of 16-bit words.
module huffman_encoder (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       sym_valid,
   input  huff_code_pkg::symbol_t     sym,
   output huff_stream_pkg::word_out_t words
);

   huff_code_pkg::code_entry_t     entry;
   logic                           entry_valid;
   huff_stream_pkg::placed_code_t  placed;
   logic                           placed_valid;
   huff_stream_pkg::shifted_code_t shifted;
   logic                           shifted_valid;

   huff_code_rom u_code_rom (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .sym_valid   (sym_valid),
      .sym         (sym),
      .entry       (entry),
      .entry_valid (entry_valid)
   );

   huff_fill_tracker u_fill_tracker (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .entry        (entry),
      .entry_valid  (entry_valid),
      .placed       (placed),
      .placed_valid (placed_valid)
   );

   huff_code_shifter u_code_shifter (
      .clk           (clk),
      .rst           (rst),
      .enable        (enable),
      .placed        (placed),
      .placed_valid  (placed_valid),
      .shifted       (shifted),
      .shifted_valid (shifted_valid)
   );

   huff_word_assembler u_word_assembler (
      .clk           (clk),
      .rst           (rst),
      .enable        (enable),
      .shifted       (shifted),
      .shifted_valid (shifted_valid),
      .words         (words)
   );

endmodule

/* huffman_encoder_assertions.sv */
`timescale 1ns/10ps

// checks on the output struct of the encoder.
module huffman_encoder_assertions (
   input logic                       clk,
   input logic                       rst,
   input logic                       enable,
   input huff_stream_pkg::word_out_t words
);

   // ############################################################
   // output count.
   // ############################################################
   // a code of at most 17 bits on top of 15 pending bits completes
   // two words at most.
   count_in_range: assert property (
      @(posedge clk) disable iff (rst) words.count != 2'd3
   ) else $error("words.count reached 3");

   count_cleared_by_reset: assert property (
      @(posedge clk) rst |=> words.count == 2'd0
   ) else $error("words.count is not zero during reset");

   // a low enable freezes the whole pipeline.
   count_frozen_without_enable: assert property (
      @(posedge clk) disable iff (rst) !enable |=> $stable(words.count)
   ) else $error("words.count changed while enable was low");

endmodule

bind huffman_encoder huffman_encoder_assertions u_assertions (
   .clk    (clk),
   .rst    (rst),
   .enable (enable),
   .words  (words)
);

/* huffman_encoder_tb.sv */
`timescale 1ns/10ps
`include "huffman_encoder_macros.svh"

module huffman_encoder_tb;

   // the ROM registers a symbol on its sampling edge and three more stages follow.
   localparam int PIPE_EDGES  = 3;
   localparam int DRAIN_LIMIT = 64;

   logic                       clk;
   logic                       rst;
   logic                       enable;
   logic                       sym_valid;
   huff_code_pkg::symbol_t     sym;
   huff_stream_pkg::word_out_t words;

   integer     seed;
   int         errors;
   int         words_seen;
   int         edge_count;
   int         start_count;
   bit         edge_enabled;
   bit         double_seen;
   logic [1:0] held_count;

   // expected bitstream with the oldest bit first.
   bit                         stream_bits[$];
   logic [`HUFF_WORD_BITS-1:0] exp_words[$];
   // enabled edge after which a word count is due, and that count.
   int                         sched_edge[$];
   int                         sched_count[$];

   huffman_encoder DUT (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .sym_valid (sym_valid),
      .sym       (sym),
      .words     (words)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ############################################################
   // reference model.
   // ############################################################
   // appends the code of one symbol to the stream and returns the
   // number of words that it completes.
   function automatic int append_code(input logic [7:0] s);
      logic [16:0]                code;
      logic [7:0]                 mid;
      logic [`HUFF_WORD_BITS-1:0] w;
      int                         len;
      int                         done;
      mid = s - 8'(`HUFF_SHORT_LIMIT);
      if (s < 8'(`HUFF_SHORT_LIMIT)) begin
         code = {12'd0, 1'b0, s[3:0]};
         len  = `HUFF_SHORT_LEN;
      end else if (s < 8'(`HUFF_MID_LIMIT)) begin
         code = {9'd0, 2'b10, mid[5:0]};
         len  = `HUFF_MID_LEN;
      end else begin
         code = {2'b11, 7'd0, s};
         len  = `HUFF_LONG_LEN;
      end
      for (int i = len - 1; i >= 0; i--) begin
         stream_bits.push_back(code[i]);
      end
      done = 0;
      while (stream_bits.size() >= `HUFF_WORD_BITS) begin
         w = '0;
         for (int i = 0; i < `HUFF_WORD_BITS; i++) begin
            w = {w[`HUFF_WORD_BITS-2:0], stream_bits.pop_front()};
         end
         exp_words.push_back(w);
         done++;
      end
      return done;
   endfunction

   task automatic check_word(input string name, input logic [`HUFF_WORD_BITS-1:0] actual);
      logic [`HUFF_WORD_BITS-1:0] expected;
      words_seen++;
      if (exp_words.size() == 0) begin
         errors++;
         $display("at %0t the DUT emitted %s with no word left in the model", $time, name);
      end else begin
         expected = exp_words.pop_front();
         if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
         end
      end
   endtask

   // ############################################################
   // comparison.
   // ############################################################
   // inputs change only by NBA, so the DUT and the model see the same values.
   always @(posedge clk) begin
      edge_enabled = 1'b0;
      if (!rst && enable) begin
         edge_count   = edge_count + 1;
         edge_enabled = 1'b1;
         if (sym_valid) begin
            sched_edge.push_back(edge_count + PIPE_EDGES);
            sched_count.push_back(append_code(sym));
         end
      end
   end

   // outputs are sampled half a period after the edge that set them.
   always @(negedge clk) begin : compare_outputs
      int exp_count;
      exp_count = 0;
      if (edge_enabled) begin
         if (sched_edge.size() > 0 && sched_edge[0] == edge_count) begin
            exp_count = sched_count.pop_front();
            void'(sched_edge.pop_front());
         end
         if (words.count !== 2'(exp_count)) begin
            errors++;
            $display("FAILED at %0t: words.count expected %0d got %0d",
                     $time, exp_count, words.count);
         end
         if (words.count == 2'd1 || words.count == 2'd2) begin
            check_word("words.first", words.first);
         end
         if (words.count == 2'd2) begin
            check_word("words.second", words.second);
            double_seen = 1'b1;
         end
      end else if (words.count !== held_count) begin
         errors++;
         $display("FAILED at %0t: words.count expected %0d got %0d",
                  $time, held_count, words.count);
      end
      held_count = words.count;
   end

   // ############################################################
   // stimulus.
   // ############################################################
   task automatic send_symbol(input huff_code_pkg::symbol_t s);
      @(posedge clk);
      enable    <= 1'b1;
      sym_valid <= 1'b1;
      sym       <= s;
   endtask

   // random symbols with gaps in sym_valid, and optional enable stalls.
   task automatic run_random(input int cycles, input bit with_stalls);
      int r;
      int stall;
      stall = 0;
      for (int i = 0; i < cycles; i++) begin
         r = $random(seed);
         @(posedge clk);
         sym       <= r[7:0];
         sym_valid <= (r[9:8] != 2'b00);
         if (stall > 0) begin
            enable <= 1'b0;
            stall--;
         end else if (with_stalls && r[13:10] == 4'hf) begin
            enable <= 1'b0;
            stall  = int'(r[17:14]);
         end else begin
            enable <= 1'b1;
         end
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      @(posedge clk);
      enable    <= 1'b1;
      sym_valid <= 1'b0;
      @(negedge clk);
      while (sched_edge.size() != 0 && cycles < DRAIN_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (sched_edge.size() != 0) begin
         errors++;
         $display("timeout: pipeline did not drain within %0d cycles", DRAIN_LIMIT);
      end
   endtask

   initial begin
      seed         = 32'h92b5;
      errors       = 0;
      words_seen   = 0;
      edge_count   = 0;
      edge_enabled = 1'b0;
      double_seen  = 1'b0;
      held_count   = 2'd0;
      rst          = 1'b1;
      enable       = 1'b0;
      sym_valid    = 1'b0;
      sym          = '0;
      repeat (16) @(posedge clk);
      rst    <= 1'b0;
      enable <= 1'b1;

      // the idle stretch must carry a zero count in every cycle.
      repeat (20) @(posedge clk);
      if (words_seen != 0) begin
         errors++;
         $display("words were emitted although no symbol was sent");
      end

      // sixteen short codes make 80 bits and so exactly five words.
      start_count = words_seen;
      for (int i = 0; i < 16; i++) begin
         send_symbol(huff_code_pkg::symbol_t'(i));
      end
      wait_drain();
      if (words_seen - start_count != 5) begin
         errors++;
         $display("FAILED at %0t: words_seen expected 5 got %0d",
                  $time, words_seen - start_count);
      end

      // 15 pending bits and a 17-bit code complete two words at once.
      double_seen = 1'b0;
      send_symbol(8'd3);
      send_symbol(8'd7);
      send_symbol(8'd12);
      send_symbol(8'd200);
      wait_drain();
      if (!double_seen) begin
         errors++;
         $display("the long code after 15 pending bits did not emit two words");
      end

      run_random(400, 1'b0);
      wait_drain();
      run_random(400, 1'b1);
      wait_drain();
      if (exp_words.size() != 0) begin
         errors++;
         $display("%0d expected words were never emitted", exp_words.size());
      end

      $display("errors: %0d, words emitted: %0d", errors, words_seen);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* huffman_encoder.f */
+incdir+.
huff_code_pkg.sv
huff_stream_pkg.sv
huff_code_rom.sv
huff_fill_tracker.sv
huff_code_shifter.sv
huff_word_assembler.sv
huffman_encoder.sv
huffman_encoder_assertions.sv
huffman_encoder_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module huffman_encoder_tb -f huffman_encoder.f

if ./obj_dir/Vhuffman_encoder_tb | tee /dev/stderr | grep "Simulation passed" > /dev/null; then
   exit 0
fi
echo "run_sim: pass message not found in the output" >&2
exit 1
